/* src/hmc_flit_pkg.sv */
// HMC packet-level types and constants for a 4-FLIT (512-bit) openHMC AXI stream
// Covers FLIT and header fields, the two supported commands and the TUSER map
// Imported by the request packer, the response decoder and the response assembler
package hmc_flit_pkg;

  // --------------------
  // Basic packet widths
  typedef logic [127:0] flit_t;
  // FLIT 0 sits in the low bits and is processed first
  typedef flit_t [3:0]  axi_word_t;
  typedef logic [63:0]  hmc_hdr_t;
  typedef logic [33:0]  hmc_addr_t;
  typedef logic [8:0]   hmc_tag_t;
  typedef logic [3:0]   pkt_len_t;
  typedef logic [5:0]   hmc_cmd_t;
  typedef logic [3:0]   err_rsp_t;
  // One bit per FLIT position
  typedef logic [3:0]   flit_mask_t;
  typedef logic [15:0]  tuser_t;

  // --------------------
  // Commands and lengths
  localparam hmc_cmd_t CMD_P_WR32 = 6'b011001;
  localparam hmc_cmd_t CMD_RD32   = 6'b110001;
  localparam pkt_len_t LEN_WR32   = 4'd3;
  localparam pkt_len_t LEN_RD32   = 4'd1;
  // Posted writes never return, so a fixed tag is enough
  localparam hmc_tag_t WR_TAG     = 9'd1;

  // Header and tail field positions
  localparam int HDR_TAG_LSB = 15;
  localparam int ERRSTAT_LSB = 20;
  localparam int ERRSTAT_W   = 7;
  typedef logic [ERRSTAT_W-1:0] errstat_t;

  // --------------------
  // TUSER map, each field is a 4-bit mask or nibble
  localparam int TU_VALID_LSB = 0;
  localparam int TU_HDR_LSB   = 4;
  localparam int TU_TAIL_LSB  = 8;
  localparam int TU_ERR_LSB   = 12;

  // Request header, CUB and reserved bits zero, DLN copies LNG
  function automatic hmc_hdr_t req_header(hmc_addr_t addr, hmc_tag_t tag,
                                          pkt_len_t len, hmc_cmd_t cmd);
    return {3'd0, 3'd0, addr, tag, len, len, 1'b0, cmd};
  endfunction

endpackage

/* src/hmc_user_pkg.sv */
// User-side types of the HMC request and response engine
// Holds the transmit and receive beat structs, the response struct
// and the FLIT class flags passed from the decoder to the assembler
package hmc_user_pkg;
  import hmc_flit_pkg::*;

  // User address counts 32-byte blocks
  typedef logic [26:0]  user_addr_t;
  typedef logic [255:0] user_data_t;

  // Transmit beat toward the controller
  typedef struct packed {
    logic      tvalid;
    axi_word_t tdata;
    tuser_t    tuser;
  } hmc_tx_beat_t;

  // Receive beat from the controller
  typedef struct packed {
    logic      tvalid;
    axi_word_t tdata;
    tuser_t    tuser;
  } hmc_rx_beat_t;

  // One returned read response
  typedef struct packed {
    hmc_tag_t   tag;
    user_data_t data;
    errstat_t   errstat;
  } rsp_t;

  // FLIT position classes of one receive beat
  typedef struct packed {
    logic full0;
    logic full1;
    logic start23;
    logic start3;
    logic end0;
    logic end01;
  } rsp_class_t;

endpackage

/* src/hmc_req_packer.sv */
// Request side of the HMC user port
// Waits for the controller start-up, then packs a P_WR32 into FLITs 0-2
// and an RD32 into FLIT 3 of a single transmit beat, one cycle after the request
`timescale 1ns/100ps

module hmc_req_packer
  import hmc_flit_pkg::*, hmc_user_pkg::*;
#(
  parameter int STARTUP_LOG2 = 8
) (
  input  logic         CLK,
  input  logic         RST,
  input  logic         post_done_i,
  input  logic         tx_tready_i,
  input  logic         wr_req_i,
  input  user_addr_t   wr_addr_i,
  input  user_data_t   wr_data_i,
  input  logic         rd_req_i,
  input  user_addr_t   rd_addr_i,
  input  hmc_tag_t     rd_tag_i,
  output logic         req_ready_o,
  output hmc_tx_beat_t tx_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_TX_RDY, ST_ACTIVE} st_e;

  st_e                     st_q;
  logic [STARTUP_LOG2-1:0] wait_cnt_q;
  logic                    req_ready_q;
  logic                    tx_valid_q;
  axi_word_t               tx_data_q;
  tuser_t                  tx_user_q;

  hmc_hdr_t   wr_hdr;
  hmc_hdr_t   rd_hdr;
  axi_word_t  beat_data;
  tuser_t     beat_user;
  flit_mask_t v_mask;
  flit_mask_t h_mask;
  flit_mask_t t_mask;

  // --------------------
  // Beat packing
  always_comb begin
    wr_hdr    = req_header({2'b00, wr_addr_i, 5'd0}, WR_TAG, LEN_WR32, CMD_P_WR32);
    rd_hdr    = req_header({2'b00, rd_addr_i, 5'd0}, rd_tag_i, LEN_RD32, CMD_RD32);
    beat_data = '0;
    v_mask    = '0;
    h_mask    = '0;
    t_mask    = '0;
    // Write: header plus data over FLITs 0-2, tail left at zero
    if (wr_req_i) begin
      beat_data[0]     = {wr_data_i[63:0], wr_hdr};
      beat_data[1]     = wr_data_i[191:64];
      beat_data[2]     = {64'd0, wr_data_i[255:192]};
      v_mask[2:0]      = 3'b111;
      h_mask[2:0]      = 3'b001;
      t_mask[2:0]      = 3'b100;
    end
    // Read fits in one FLIT, header and tail both in FLIT 3
    if (rd_req_i) begin
      beat_data[3] = {64'd0, rd_hdr};
      v_mask[3]    = 1'b1;
      h_mask[3]    = 1'b1;
      t_mask[3]    = 1'b1;
    end
    beat_user                     = '0;
    beat_user[TU_VALID_LSB +: 4]  = v_mask;
    beat_user[TU_HDR_LSB +: 4]    = h_mask;
    beat_user[TU_TAIL_LSB +: 4]   = t_mask;
  end

  // --------------------
  // Start-up FSM and transmit strobe
  always_ff @(posedge CLK) begin
    if (RST) begin
      st_q        <= ST_IDLE;
      wait_cnt_q  <= '0;
      req_ready_q <= 1'b0;
      tx_valid_q  <= 1'b0;
    end else begin
      tx_valid_q  <= 1'b0;
      req_ready_q <= 1'b0;
      case (st_q)
        ST_IDLE: begin
          // Give the link time to settle once POST is done
          if (post_done_i) begin
            wait_cnt_q <= wait_cnt_q + STARTUP_LOG2'(1);
            if (&wait_cnt_q) begin
              st_q <= ST_WAIT_TX_RDY;
            end
          end
        end
        ST_WAIT_TX_RDY: begin
          // Ready follows transmit ready from the first active cycle on
          req_ready_q <= tx_tready_i;
          if (tx_tready_i) begin
            st_q <= ST_ACTIVE;
          end
        end
        ST_ACTIVE: begin
          // One-cycle beat per sampled request, never held
          tx_valid_q  <= wr_req_i | rd_req_i;
          req_ready_q <= tx_tready_i;
        end
        default: st_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    tx_data_q <= beat_data;
    tx_user_q <= beat_user;
  end

  assign req_ready_o = req_ready_q;
  assign tx_o        = '{tvalid: tx_valid_q, tdata: tx_data_q, tuser: tx_user_q};

endmodule

/* src/hmc_rsp_flit_decode.sv */
// Receive register stage and FLIT position classifier
// Captures each accepted receive beat and presents it with its class flags
// one cycle later; the stage holds its content while the ready level is low
`timescale 1ns/100ps

module hmc_rsp_flit_decode
  import hmc_flit_pkg::*, hmc_user_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  hmc_rx_beat_t rx_i,
  input  logic         rx_ready_i,
  output logic         dec_valid_o,
  output hmc_rx_beat_t dec_beat_o,
  output rsp_class_t   dec_class_o
);

  flit_mask_t   v_m;
  flit_mask_t   h_m;
  flit_mask_t   t_m;
  rsp_class_t   cls;
  logic         dec_valid_q;
  hmc_rx_beat_t beat_q;
  rsp_class_t   cls_q;

  assign v_m = rx_i.tuser[TU_VALID_LSB +: 4];
  assign h_m = rx_i.tuser[TU_HDR_LSB +: 4];
  assign t_m = rx_i.tuser[TU_TAIL_LSB +: 4];

  // --------------------
  // Mask patterns
  always_comb begin
    // Complete 3-FLIT response at FLITs 0-2 or 1-3
    cls.full0   = (v_m[2:0] == 3'b111) && (h_m[2:0] == 3'b001) && (t_m[2:0] == 3'b100);
    cls.full1   = (v_m[3:1] == 3'b111) && (h_m[3:1] == 3'b001) && (t_m[3:1] == 3'b100);
    // Header near the top, rest follows in the next beat
    cls.start23 = (v_m[3:2] == 2'b11) && (h_m[3:2] == 2'b01) && (t_m[3:2] == 2'b00);
    cls.start3  = v_m[3] && h_m[3] && !t_m[3];
    // Tail of a split response at the bottom
    cls.end0    = v_m[0] && !h_m[0] && t_m[0];
    cls.end01   = (v_m[1:0] == 2'b11) && (h_m[1:0] == 2'b00) && (t_m[1:0] == 2'b10);
  end

  // Valid only moves while ready, so a stalled beat stays in place
  always_ff @(posedge CLK) begin
    if (RST) begin
      dec_valid_q <= 1'b0;
    end else if (rx_ready_i) begin
      dec_valid_q <= rx_i.tvalid;
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_ready_i && rx_i.tvalid) begin
      beat_q <= rx_i;
      cls_q  <= cls;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_beat_o  = beat_q;
  assign dec_class_o = cls_q;

endmodule

/* src/hmc_rsp_assemble.sv */
// Read response assembler
// Builds responses from decoded beats, joins responses split over two beats
// and spreads a beat that ends one response and carries another over two cycles
`timescale 1ns/100ps

module hmc_rsp_assemble
  import hmc_flit_pkg::*, hmc_user_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         post_done_i,
  input  logic         dec_valid_i,
  input  hmc_rx_beat_t dec_beat_i,
  input  rsp_class_t   dec_class_i,
  output logic         rx_tready_o,
  output logic         rsp_valid_o,
  output rsp_t         rsp_o,
  output err_rsp_t     flit_error_resp_o
);

  typedef enum logic [1:0] {PEND_NONE, PEND_LOW3, PEND_LOW1} pend_e;

  pend_e        pend_q;
  logic [191:0] pend_data_q;
  hmc_tag_t     pend_tag_q;
  logic         started_q;
  logic         rx_ready_q;
  logic         hold_valid_q;
  rsp_t         hold_q;
  logic         rsp_valid_q;
  rsp_t         rsp_q;
  err_rsp_t     err_q;

  axi_word_t w;
  logic      take;
  logic      end_hit;
  logic      double_hit;
  logic      rsp_hit;
  rsp_t      full0_rsp;
  rsp_t      full1_rsp;
  rsp_t      end_rsp;
  rsp_t      rsp_d;

  function automatic hmc_tag_t hdr_tag(flit_t f);
    return f[HDR_TAG_LSB +: $bits(hmc_tag_t)];
  endfunction

  // Tail lives in the upper half of its FLIT
  function automatic errstat_t tail_errstat(flit_t f);
    return f[64 + ERRSTAT_LSB +: ERRSTAT_W];
  endfunction

  // Header FLIT k, data across k..k+2, tail in the top of k+2
  function automatic rsp_t full_rsp(axi_word_t wd, int unsigned k);
    rsp_t r;
    r.tag     = hdr_tag(wd[k]);
    r.data    = {wd[k+2][63:0], wd[k+1], wd[k][127:64]};
    r.errstat = tail_errstat(wd[k+2]);
    return r;
  endfunction

  // --------------------
  // Response selection
  always_comb begin
    w          = dec_beat_i.tdata;
    // Skip decoding in the hold cycle, the stalled beat is taken next cycle
    take       = dec_valid_i && started_q && !hold_valid_q;
    end_hit    = take && (((pend_q == PEND_LOW3) && dec_class_i.end0) ||
                          ((pend_q == PEND_LOW1) && dec_class_i.end01));
    double_hit = end_hit && dec_class_i.full1;
    full0_rsp  = full_rsp(w, 0);
    full1_rsp  = full_rsp(w, 1);
    end_rsp.tag = pend_tag_q;
    if (pend_q == PEND_LOW1) begin
      end_rsp.data    = {w[1][63:0], w[0], pend_data_q[63:0]};
      end_rsp.errstat = tail_errstat(w[1]);
    end else begin
      end_rsp.data    = {w[0][63:0], pend_data_q};
      end_rsp.errstat = tail_errstat(w[0]);
    end
    rsp_hit = end_hit || (take && (dec_class_i.full0 || dec_class_i.full1));
    // Split response goes first, FLIT 1 response is held on a double beat
    if (end_hit) begin
      rsp_d = end_rsp;
    end else if (dec_class_i.full1) begin
      rsp_d = full1_rsp;
    end else begin
      rsp_d = full0_rsp;
    end
  end

  // --------------------
  // Control state
  always_ff @(posedge CLK) begin
    if (RST) begin
      started_q    <= 1'b0;
      pend_q       <= PEND_NONE;
      rx_ready_q   <= 1'b0;
      hold_valid_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      err_q        <= '0;
    end else begin
      if (post_done_i) begin
        started_q <= 1'b1;
      end
      rx_ready_q   <= !double_hit;
      hold_valid_q <= double_hit;
      rsp_valid_q  <= rsp_hit || hold_valid_q;
      err_q        <= take ? dec_beat_i.tuser[TU_ERR_LSB +: 4] : '0;
      // A new start in the same beat restarts pending
      if (take) begin
        if (dec_class_i.start23) begin
          pend_q <= PEND_LOW3;
        end else if (dec_class_i.start3) begin
          pend_q <= PEND_LOW1;
        end else if (end_hit) begin
          pend_q <= PEND_NONE;
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if (take && dec_class_i.start23) begin
      pend_tag_q  <= hdr_tag(w[2]);
      pend_data_q <= {w[3], w[2][127:64]};
    end else if (take && dec_class_i.start3) begin
      pend_tag_q        <= hdr_tag(w[3]);
      pend_data_q[63:0] <= w[3][127:64];
    end
    if (double_hit) begin
      hold_q <= full1_rsp;
    end
    if (hold_valid_q) begin
      rsp_q <= hold_q;
    end else if (rsp_hit) begin
      rsp_q <= rsp_d;
    end
  end

  assign rx_tready_o       = rx_ready_q;
  assign rsp_valid_o       = rsp_valid_q;
  assign rsp_o             = rsp_q;
  assign flit_error_resp_o = err_q;

endmodule

/* src/hmc_user_top.sv */
// Top level of the HMC user port request and response engine
// Connects the request packer, the receive FLIT decoder and the response
// assembler to one openHMC AXI stream pair; STARTUP_LOG2 sets the start-up wait
`timescale 1ns/100ps

module hmc_user_top
  import hmc_flit_pkg::*, hmc_user_pkg::*;
#(
  parameter int STARTUP_LOG2 = 8
) (
  input  logic         CLK,
  input  logic         RST,
  input  logic         post_done_i,
  output hmc_tx_beat_t tx_o,
  input  logic         tx_tready_i,
  input  hmc_rx_beat_t rx_i,
  output logic         rx_tready_o,
  input  user_addr_t   wr_addr_i,
  input  user_data_t   wr_data_i,
  input  logic         wr_req_i,
  output logic         wr_ready_o,
  input  user_addr_t   rd_addr_i,
  input  hmc_tag_t     rd_tag_i,
  input  logic         rd_req_i,
  output logic         rd_ready_o,
  output logic         rsp_valid_o,
  output rsp_t         rsp_o,
  output err_rsp_t     flit_error_resp_o
);

  logic         req_ready;
  logic         rx_tready;
  logic         dec_valid;
  hmc_rx_beat_t dec_beat;
  rsp_class_t   dec_class;

  // Transmit side
  hmc_req_packer #(
    .STARTUP_LOG2(STARTUP_LOG2)
  ) u_packer (
    .CLK(CLK), .RST(RST), .post_done_i(post_done_i), .tx_tready_i(tx_tready_i),
    .wr_req_i(wr_req_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
    .rd_req_i(rd_req_i), .rd_addr_i(rd_addr_i), .rd_tag_i(rd_tag_i),
    .req_ready_o(req_ready), .tx_o(tx_o)
  );

  // Receive side, register stage then assembly
  hmc_rsp_flit_decode u_decode (
    .CLK(CLK), .RST(RST), .rx_i(rx_i), .rx_ready_i(rx_tready),
    .dec_valid_o(dec_valid), .dec_beat_o(dec_beat), .dec_class_o(dec_class)
  );

  hmc_rsp_assemble u_assemble (
    .CLK(CLK), .RST(RST), .post_done_i(post_done_i),
    .dec_valid_i(dec_valid), .dec_beat_i(dec_beat), .dec_class_i(dec_class),
    .rx_tready_o(rx_tready), .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
    .flit_error_resp_o(flit_error_resp_o)
  );

  // Both request paths share one ready level
  assign wr_ready_o  = req_ready;
  assign rd_ready_o  = req_ready;
  assign rx_tready_o = rx_tready;

endmodule

/* verification/hmc_user_assert.sv */
// Concurrent checks on the handshake levels of the HMC user port
// Attached to the top level by bind, reports only through assertion failures
`timescale 1ns/100ps

module hmc_user_assert (
  input logic CLK,
  input logic RST,
  input logic tx_valid_i,
  input logic req_ready_i,
  input logic rx_tready_i,
  input logic rsp_valid_i
);

  logic ready_seen_q;

  // Remembers that the request side has been ready once
  always_ff @(posedge CLK) begin
    if (RST) begin
      ready_seen_q <= 1'b0;
    end else if (req_ready_i) begin
      ready_seen_q <= 1'b1;
    end
  end

  // No transmit beat before the first ready level
  a_tx_after_ready : assert property (@(posedge CLK) disable iff (RST)
    tx_valid_i |-> ready_seen_q)
    else $error("transmit beat before request ready was ever high");

  // Receive stall lasts one cycle at most
  a_rx_stall_short : assert property (@(posedge CLK) disable iff (RST)
    !rx_tready_i |=> rx_tready_i)
    else $error("receive ready low for two cycles in a row");

  a_no_rsp_in_reset : assert property (@(posedge CLK) RST |=> !rsp_valid_i)
    else $error("response valid while in reset");

endmodule

bind hmc_user_top hmc_user_assert u_assert (
  .CLK(CLK),
  .RST(RST),
  .tx_valid_i(tx_o.tvalid),
  .req_ready_i(wr_ready_o),
  .rx_tready_i(rx_tready_o),
  .rsp_valid_i(rsp_valid_o)
);

/* verification/tb_hmc_user_top.sv */
// Testbench for the HMC user port engine
// Drives write and read requests and returned response beats, builds the
// expected transmit beats and responses from the packet rules and compares them
`timescale 1ns/100ps

module tb_hmc_user_top
  import hmc_flit_pkg::*, hmc_user_pkg::*;
();

  localparam int STARTUP_LOG2 = 4;
  localparam int RST_CYCLES   = 5;
  localparam int N_TESTS      = 8;
  localparam int TEST_CYCLES  = 20;
  // Reset, start-up wait and a fixed budget per test
  localparam int WATCHDOG_CYCLES = RST_CYCLES + (1 << STARTUP_LOG2) + 8 + N_TESTS * TEST_CYCLES;
  // First cycle with request ready, after the start-up count and one wait cycle
  localparam int READY_CYC = RST_CYCLES + (1 << STARTUP_LOG2) + 1;

  typedef flit_t [2:0] pkt3_t;

  logic         CLK;
  logic         RST;
  logic         post_done_i;
  hmc_tx_beat_t tx_o;
  logic         tx_tready_i;
  hmc_rx_beat_t rx_i;
  logic         rx_tready_o;
  user_addr_t   wr_addr_i;
  user_data_t   wr_data_i;
  logic         wr_req_i;
  logic         wr_ready_o;
  user_addr_t   rd_addr_i;
  hmc_tag_t     rd_tag_i;
  logic         rd_req_i;
  logic         rd_ready_o;
  logic         rsp_valid_o;
  rsp_t         rsp_o;
  err_rsp_t     flit_error_resp_o;

  int    seed       = 64;
  int    cyc        = 0;
  int    last_due   = 0;
  int    rx_low_cnt = 0;
  string test_name  = "reset";

  // Expected items with the cycle in which they must show up
  hmc_tx_beat_t exp_tx_q[$];
  int           exp_tx_due_q[$];
  rsp_t         exp_rsp_q[$];
  int           exp_rsp_due_q[$];
  err_rsp_t     exp_err_at[int];
  err_rsp_t     exp_err_now;
  logic         exp_ready;

  hmc_user_top #(
    .STARTUP_LOG2(STARTUP_LOG2)
  ) dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  // --------------------
  // Reference functions
  function automatic user_data_t rand_data();
    user_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  function automatic rsp_t rand_rsp();
    rsp_t r;
    r.tag     = hmc_tag_t'($random(seed));
    r.data    = rand_data();
    r.errstat = errstat_t'($random(seed));
    return r;
  endfunction

  // CUB and reserved zero, address in 32-byte units shifted up by five
  function automatic logic [63:0] make_header(user_addr_t a, hmc_tag_t tag,
                                               pkt_len_t len, hmc_cmd_t cmd);
    logic [63:0] h;
    h        = '0;
    h[5:0]   = cmd;
    h[10:7]  = len;
    h[14:11] = len;
    h[23:15] = tag;
    h[57:24] = {2'b00, a, 5'd0};
    return h;
  endfunction

  function automatic hmc_tx_beat_t expected_tx(logic wr, user_addr_t wa, user_data_t wd,
                                               logic rd, user_addr_t ra, hmc_tag_t rt);
    hmc_tx_beat_t b;
    flit_mask_t   v;
    flit_mask_t   h;
    flit_mask_t   t;
    b        = '0;
    v        = '0;
    h        = '0;
    t        = '0;
    b.tvalid = 1'b1;
    if (wr) begin
      b.tdata[0] = {wd[63:0], make_header(wa, WR_TAG, LEN_WR32, CMD_P_WR32)};
      b.tdata[1] = wd[191:64];
      b.tdata[2] = {64'd0, wd[255:192]};
      v = v | 4'b0111;
      h = h | 4'b0001;
      t = t | 4'b0100;
    end
    if (rd) begin
      b.tdata[3] = {64'd0, make_header(ra, rt, LEN_RD32, CMD_RD32)};
      v = v | 4'b1000;
      h = h | 4'b1000;
      t = t | 4'b1000;
    end
    b.tuser = {4'h0, t, h, v};
    return b;
  endfunction

  // Read response as three FLITs, header then data then tail
  function automatic pkt3_t rsp_packet(rsp_t r);
    logic [63:0] hdr;
    logic [63:0] tail;
    pkt3_t       p;
    hdr        = '0;
    hdr[5:0]   = 6'b111000;
    hdr[10:7]  = 4'd3;
    hdr[14:11] = 4'd3;
    hdr[23:15] = r.tag;
    tail       = '0;
    tail[26:20] = r.errstat;
    p[0] = {r.data[63:0], hdr};
    p[1] = r.data[191:64];
    p[2] = {tail, r.data[255:192]};
    return p;
  endfunction

  function automatic hmc_rx_beat_t rx_beat(axi_word_t d, flit_mask_t v, flit_mask_t h,
                                           flit_mask_t t, err_rsp_t e);
    hmc_rx_beat_t b;
    b.tvalid = 1'b1;
    b.tdata  = d;
    b.tuser  = {e, t, h, v};
    return b;
  endfunction

  // --------------------
  // Reporting
  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at cycle %0d", cyc);
  endtask

  task automatic check(string what, logic [511:0] exp_v, logic [511:0] act_v);
    if (exp_v !== act_v) begin
      abort_run($sformatf("Error: %s %s expected %0h actual %0h",
                          test_name, what, exp_v, act_v));
    end
  endtask

  // --------------------
  // Stimulus tasks
  task automatic send_req(logic wr, user_addr_t wa, user_data_t wd,
                          logic rd, user_addr_t ra, hmc_tag_t rt);
    @(negedge CLK);
    while (!wr_ready_o) @(negedge CLK);
    @(posedge CLK);
    wr_req_i  <= wr;
    wr_addr_i <= wa;
    wr_data_i <= wd;
    rd_req_i  <= rd;
    rd_addr_i <= ra;
    rd_tag_i  <= rt;
    // Beat expected one cycle after the sampling edge
    exp_tx_q.push_back(expected_tx(wr, wa, wd, rd, ra, rt));
    exp_tx_due_q.push_back(cyc + 2);
    if (cyc + 2 > last_due) last_due = cyc + 2;
    @(posedge CLK);
    wr_req_i <= 1'b0;
    rd_req_i <= 1'b0;
  endtask

  task automatic send_rx(hmc_rx_beat_t b, output int due);
    @(negedge CLK);
    while (!rx_tready_o) @(negedge CLK);
    @(posedge CLK);
    rx_i <= b;
    // Register stage plus assembly, two cycles after acceptance
    due = cyc + 3;
    exp_err_at[due] = b.tuser[15:12];
    if (due > last_due) last_due = due;
    @(posedge CLK);
    rx_i.tvalid <= 1'b0;
  endtask

  task automatic expect_rsp(rsp_t r, int due);
    exp_rsp_q.push_back(r);
    exp_rsp_due_q.push_back(due);
    if (due > last_due) last_due = due;
  endtask

  task automatic drain();
    @(negedge CLK);
    while (exp_tx_q.size() != 0 || exp_rsp_q.size() != 0 || cyc <= last_due) begin
      @(negedge CLK);
    end
  endtask

  // --------------------
  // Comparison process, outputs sampled on the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      // Transmit ready stays high after reset, so ready holds once it rises
      exp_ready = (cyc >= READY_CYC);
      check("wr ready", 512'(exp_ready), 512'(wr_ready_o));
      check("rd ready", 512'(exp_ready), 512'(rd_ready_o));
      if (tx_o.tvalid) begin
        if (exp_tx_q.size() == 0) begin
          abort_run($sformatf("Unexpected transmit beat in test %s", test_name));
        end else begin
          check("tx cycle", 512'(exp_tx_due_q[0]), 512'(cyc));
          check("tx tdata", 512'(exp_tx_q[0].tdata), 512'(tx_o.tdata));
          check("tx tuser", 512'(exp_tx_q[0].tuser), 512'(tx_o.tuser));
          void'(exp_tx_q.pop_front());
          void'(exp_tx_due_q.pop_front());
        end
      end
      if (exp_tx_due_q.size() != 0 && exp_tx_due_q[0] < cyc) begin
        abort_run($sformatf("Transmit beat missing in test %s", test_name));
      end
      if (rsp_valid_o) begin
        if (exp_rsp_q.size() == 0) begin
          abort_run($sformatf("Unexpected response in test %s", test_name));
        end else begin
          check("rsp cycle", 512'(exp_rsp_due_q[0]), 512'(cyc));
          check("rsp tag", 512'(exp_rsp_q[0].tag), 512'(rsp_o.tag));
          check("rsp data", 512'(exp_rsp_q[0].data), 512'(rsp_o.data));
          check("rsp errstat", 512'(exp_rsp_q[0].errstat), 512'(rsp_o.errstat));
          void'(exp_rsp_q.pop_front());
          void'(exp_rsp_due_q.pop_front());
        end
      end
      if (exp_rsp_due_q.size() != 0 && exp_rsp_due_q[0] < cyc) begin
        abort_run($sformatf("Response missing in test %s", test_name));
      end
      // Error nibble only in the cycle of its decoded beat
      exp_err_now = exp_err_at.exists(cyc) ? exp_err_at[cyc] : 4'h0;
      check("error nibble", 512'(exp_err_now), 512'(flit_error_resp_o));
      if (cyc > RST_CYCLES + 1 && !rx_tready_o) begin
        rx_low_cnt = rx_low_cnt + 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    abort_run($sformatf("Watchdog expired during test %s", test_name));
  end

  // --------------------
  // Test sequence
  initial begin
    user_addr_t a0;
    user_addr_t a1;
    user_data_t d0;
    hmc_tag_t   t0;
    rsp_t       r0;
    rsp_t       r1;
    pkt3_t      p0;
    pkt3_t      p1;
    axi_word_t  w;
    int         due;
    int         n0;

    RST         = 1'b1;
    post_done_i = 1'b0;
    tx_tready_i = 1'b0;
    rx_i        = '0;
    wr_addr_i   = '0;
    wr_data_i   = '0;
    wr_req_i    = 1'b0;
    rd_addr_i   = '0;
    rd_tag_i    = '0;
    rd_req_i    = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    RST         <= 1'b0;
    post_done_i <= 1'b1;
    tx_tready_i <= 1'b1;

    // Posted write alone, then read alone, then both in one beat
    test_name = "write only";
    a0 = user_addr_t'($random(seed));
    d0 = rand_data();
    send_req(1'b1, a0, d0, 1'b0, '0, '0);
    drain();
    test_name = "read only";
    a1 = user_addr_t'($random(seed));
    t0 = hmc_tag_t'($random(seed));
    send_req(1'b0, '0, '0, 1'b1, a1, t0);
    drain();
    test_name = "write and read";
    a0 = user_addr_t'($random(seed));
    a1 = user_addr_t'($random(seed));
    d0 = rand_data();
    t0 = hmc_tag_t'($random(seed));
    send_req(1'b1, a0, d0, 1'b1, a1, t0);
    drain();

    test_name = "full at flit 0";
    r0 = rand_rsp();
    p0 = rsp_packet(r0);
    w  = '0;
    w[2:0] = p0;
    send_rx(rx_beat(w, 4'b0111, 4'b0001, 4'b0100, 4'hA), due);
    expect_rsp(r0, due);
    drain();
    test_name = "full at flit 1";
    r0 = rand_rsp();
    p0 = rsp_packet(r0);
    w  = '0;
    w[3:1] = p0;
    send_rx(rx_beat(w, 4'b1110, 4'b0010, 4'b1000, 4'h0), due);
    expect_rsp(r0, due);
    drain();

    // Split responses over two beats
    test_name = "split 2-3 plus 0";
    r0 = rand_rsp();
    p0 = rsp_packet(r0);
    w  = '0;
    w[3:2] = p0[1:0];
    send_rx(rx_beat(w, 4'b1100, 4'b0100, 4'b0000, 4'h3), due);
    w    = '0;
    w[0] = p0[2];
    send_rx(rx_beat(w, 4'b0001, 4'b0000, 4'b0001, 4'h0), due);
    expect_rsp(r0, due);
    drain();
    test_name = "split 3 plus 0-1";
    r0 = rand_rsp();
    p0 = rsp_packet(r0);
    w    = '0;
    w[3] = p0[0];
    send_rx(rx_beat(w, 4'b1000, 4'b1000, 4'b0000, 4'h0), due);
    w = '0;
    w[1:0] = p0[2:1];
    send_rx(rx_beat(w, 4'b0011, 4'b0000, 4'b0010, 4'hC), due);
    expect_rsp(r0, due);
    drain();

    // Split end plus full response in one beat
    test_name = "double response";
    n0 = rx_low_cnt;
    r0 = rand_rsp();
    r1 = rand_rsp();
    p0 = rsp_packet(r0);
    p1 = rsp_packet(r1);
    w  = '0;
    w[3:2] = p0[1:0];
    send_rx(rx_beat(w, 4'b1100, 4'b0100, 4'b0000, 4'h0), due);
    w      = '0;
    w[0]   = p0[2];
    w[3:1] = p1;
    send_rx(rx_beat(w, 4'b1111, 4'b0010, 4'b1001, 4'h5), due);
    expect_rsp(r0, due);
    expect_rsp(r1, due + 1);
    drain();
    check("rx ready low cycles", 512'(1), 512'(rx_low_cnt - n0));

    $display("TEST OK");
    $finish;
  end

endmodule

/* project.f */
src/hmc_flit_pkg.sv
src/hmc_user_pkg.sv
src/hmc_req_packer.sv
src/hmc_rsp_flit_decode.sv
src/hmc_rsp_assemble.sv
src/hmc_user_top.sv
verification/hmc_user_assert.sv
verification/tb_hmc_user_top.sv

/* Makefile */
TOP := tb_hmc_user_top
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
